/* hw/fpn_defines.svh */
`ifndef FPN_DEFINES_SVH
`define FPN_DEFINES_SVH

// width of the signed significand sum coming out of the adder
`define FPN_SUM_W 19

// width of the normalized mantissa, the leading one included
`define FPN_MANT_W 11

// width of the signed exponent adjustment reported with each result
`define FPN_EXP_DIFF_W 5

// number of magnitude bits that take part in the leading-one search
`define FPN_LEAD_W 15

// lowest magnitude bit that the leading-one search looks at
`define FPN_LEAD_LSB 3

// a leading one at this magnitude bit needs no exponent change
`define FPN_POINT_POS 13

`endif

/* hw/fpn_pkg.sv */
`include "fpn_defines.svh"

package fpn_pkg;

    // output of the first stage, registered after leading-one detection
    // lead_vec is one-hot, and bit 14 of it stands for magnitude bit 17
    typedef struct packed {
        logic                   sign;
        logic [`FPN_SUM_W-1:0]  mag;
        logic [`FPN_LEAD_W-1:0] lead_vec;
    } lod_stage_t;

    // combinational output of the normalizer, read by the rounder
    // the guard bit is not carried, it is the lowest mantissa bit
    typedef struct packed {
        logic                              sign;
        logic [`FPN_MANT_W-1:0]            mant;
        logic signed [`FPN_EXP_DIFF_W-1:0] exp_diff;
        logic                              round;
        logic                              sticky;
    } norm_stage_t;

    // final registered result of the unit
    // exp_carry asks the exponent logic for one more increment after rounding
    typedef struct packed {
        logic                              sign;
        logic                              exp_carry;
        logic signed [`FPN_EXP_DIFF_W-1:0] exp_diff;
        logic [`FPN_MANT_W-1:0]            mant;
    } norm_result_t;

endpackage

/* hw/fpn_magnitude_lod.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_magnitude_lod (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_valid,
    input  logic signed [`FPN_SUM_W-1:0] i_sum,
    output logic                         o_valid,
    output fpn_pkg::lod_stage_t          o_stage
);

    // sign of the sum and its absolute value
    logic                   sum_sign;
    logic [`FPN_SUM_W-1:0]  inv_sum;
    logic [`FPN_SUM_W-1:0]  neg_sum;
    logic [`FPN_SUM_W-1:0]  mag;

    // one-hot marker of the highest set bit in the searched window
    logic [`FPN_LEAD_W-1:0] lead_vec;

    // stage register contents
    logic                   valid_q;
    fpn_pkg::lod_stage_t    stage_q;

    // the sum is two's complement, so its top bit is the sign
    assign sum_sign = i_sum[`FPN_SUM_W-1];

    // negation is invert and add one, as in a plain adder
    assign inv_sum = ~i_sum;
    assign neg_sum = inv_sum + 1'b1;

    // the most negative sum negates to itself, which reads as bit 18 alone
    // in the unsigned magnitude and so falls outside the search window
    assign mag = sum_sign ? neg_sum : i_sum;

    // scan from bit 17 downwards and keep a running OR of the bits above
    // a position is marked only when it is set and nothing above it was
    always_comb begin : lod_scan
        logic seen;
        seen = 1'b0;
        for (int i = `FPN_LEAD_W - 1; i >= 0; i--) begin
            lead_vec[i] = mag[i + `FPN_LEAD_LSB] & ~seen;
            seen        = seen | mag[i + `FPN_LEAD_LSB];
        end
    end

    // valid strobe of stage 1
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    // stage 1 payload only moves when a sample is offered
    // otherwise the last sample stays put for the normalizer
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            stage_q.sign     <= sum_sign;
            stage_q.mag      <= mag;
            stage_q.lead_vec <= lead_vec;
        end
    end

    assign o_valid = valid_q;
    assign o_stage = stage_q;

endmodule

/* hw/fpn_normalizer.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_normalizer (
    input  fpn_pkg::lod_stage_t  i_stage,
    output fpn_pkg::norm_stage_t o_norm
);

    // highest searched magnitude bit, 17
    localparam int TOP_POS = `FPN_LEAD_LSB + `FPN_LEAD_W - 1;

    // bits needed to hold a magnitude bit position up to TOP_POS
    localparam int POS_W = $clog2(TOP_POS + 1);

    // position of the round bit inside the shifted magnitude
    localparam int RND_POS = TOP_POS - `FPN_MANT_W;

    localparam int EXP_W = `FPN_EXP_DIFF_W;

    // set when the first stage found a leading one at all
    logic                  hit;

    // magnitude bit position p of the leading one
    logic [POS_W-1:0]      lead_pos;

    // distance that brings bit p up to TOP_POS
    logic [POS_W-1:0]      shift_amt;

    // magnitude with the leading one moved to TOP_POS
    logic [`FPN_SUM_W-1:0] shifted;

    // mantissa, exponent and rounding fields before the no-hit clear
    logic [`FPN_MANT_W-1:0] mant;
    logic [EXP_W-1:0]       exp_diff;
    logic                   round_bit;
    logic                   sticky_bit;

    assign hit = |i_stage.lead_vec;

    // turn the one-hot vector back into a bit position
    // at most one bit is set, so the loop is a plain encoder
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < `FPN_LEAD_W; i++) begin
            if (i_stage.lead_vec[i]) begin
                lead_pos = POS_W'(i + `FPN_LEAD_LSB);
            end
        end
    end

    // shifting left zero-fills from below, which gives the zero-filled
    // mantissa tail for small p and clears the round and sticky bits
    // when p is too low to reach them
    assign shift_amt = POS_W'(TOP_POS) - lead_pos;
    assign shifted   = i_stage.mag << shift_amt;

    // mantissa is magnitude bits p down to p-10
    assign mant = shifted[TOP_POS -: `FPN_MANT_W];

    // round bit is magnitude bit p-11
    assign round_bit = shifted[RND_POS];

    // sticky collects everything below the round bit
    assign sticky_bit = |shifted[RND_POS-1:0];

    // a leading one at bit 13 keeps the exponent, each bit above adds one
    // and each bit below takes one away, so the difference is p-13
    // modulo arithmetic on EXP_W bits gives the two's-complement result
    assign exp_diff = EXP_W'(lead_pos) - EXP_W'(`FPN_POINT_POS);

    // with no leading one the sum is too small to normalize here
    // and every field goes to zero, the sign is still passed on
    always_comb begin
        o_norm.sign = i_stage.sign;
        if (hit) begin
            o_norm.mant     = mant;
            o_norm.exp_diff = exp_diff;
            o_norm.round    = round_bit;
            o_norm.sticky   = sticky_bit;
        end else begin
            o_norm.mant     = '0;
            o_norm.exp_diff = '0;
            o_norm.round    = 1'b0;
            o_norm.sticky   = 1'b0;
        end
    end

endmodule

/* hw/fpn_rne_rounder.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_rne_rounder (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  fpn_pkg::norm_stage_t  i_norm,
    output logic                  o_valid,
    output fpn_pkg::norm_result_t o_result
);

    // guard is the last mantissa bit that survives
    logic                   guard_bit;

    // set when the mantissa has to be bumped by one
    logic                   round_up;

    // mantissa with one extra bit on top to catch the carry
    logic [`FPN_MANT_W:0]   mant_rne;

    // carry out of the increment and the renormalized mantissa
    logic                   exp_carry;
    logic [`FPN_MANT_W-1:0] final_mant;

    // output registers
    logic                   valid_q;
    fpn_pkg::norm_result_t  result_q;

    assign guard_bit = i_norm.mant[0];

    // increment on a round bit when either the guard or the sticky bit is set
    // an exact tie with an even guard bit is left alone
    assign round_up = i_norm.round & (guard_bit | i_norm.sticky);

    assign mant_rne = {1'b0, i_norm.mant} + {{`FPN_MANT_W{1'b0}}, round_up};

    // an all-ones mantissa overflows into bit 11 when rounded up
    assign exp_carry = mant_rne[`FPN_MANT_W];

    // after a carry the one sits in bit 11, so drop the lowest bit
    // the bit dropped is always zero because the value is a power of two
    assign final_mant = exp_carry ? mant_rne[`FPN_MANT_W:1]
                                  : mant_rne[`FPN_MANT_W-1:0];

    // valid and result both clear on reset
    // result only loads with a valid sample and holds otherwise
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q  <= 1'b0;
            result_q <= '0;
        end else begin
            valid_q <= i_valid;
            if (i_valid) begin
                result_q.sign      <= i_norm.sign;
                result_q.exp_carry <= exp_carry;
                result_q.exp_diff  <= i_norm.exp_diff;
                result_q.mant      <= final_mant;
            end
        end
    end

    assign o_valid  = valid_q;
    assign o_result = result_q;

endmodule

/* hw/fpn_norm_round_top.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_norm_round_top (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_valid,
    input  logic signed [`FPN_SUM_W-1:0] i_sum,
    output logic                         o_valid,
    output fpn_pkg::norm_result_t        o_result
);

    // stage 1 outputs, registered right after leading-one detection
    logic                 lod_valid;
    fpn_pkg::lod_stage_t  lod_stage;

    // normalizer output, combinational between the two registers
    fpn_pkg::norm_stage_t norm_stage;

    // sign, magnitude and leading-one vector, first register
    fpn_magnitude_lod u_magnitude_lod (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_sum    (i_sum),
        .o_valid  (lod_valid),
        .o_stage  (lod_stage)
    );

    // shift, exponent difference, round and sticky bits
    // the valid bit goes straight past it to the rounder
    fpn_normalizer u_normalizer (
        .i_stage (lod_stage),
        .o_norm  (norm_stage)
    );

    // round to nearest even and the second register
    fpn_rne_rounder u_rne_rounder (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (lod_valid),
        .i_norm   (norm_stage),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

endmodule

/* test/fpn_norm_round_sva.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_norm_round_sva (
    input logic                         i_clk,
    input logic                         i_arst_n,
    input logic                         i_valid,
    input logic signed [`FPN_SUM_W-1:0] i_sum,
    input logic                         o_valid,
    input fpn_pkg::norm_result_t        o_result
);

    // read by the testbench at the end of the run
    int fail_cnt = 0;

    // i_valid and i_sum as they were one and two edges back
    logic [1:0]             vld_hist;
    logic [`FPN_SUM_W-1:0]  sum_d1;
    logic [`FPN_SUM_W-1:0]  sum_d2;

    // o_result as it was one edge back, for the hold check
    fpn_pkg::norm_result_t  prev_result;

    // model output for the sample taken two edges back
    fpn_pkg::norm_result_t  exp_result;

    // reference model written from the normalize and round rules
    function automatic fpn_pkg::norm_result_t model_result(input logic [`FPN_SUM_W-1:0] sum);
        fpn_pkg::norm_result_t  r;
        logic [`FPN_SUM_W-1:0]  mag;
        logic [`FPN_SUM_W-1:0]  tmp;
        logic [`FPN_SUM_W-1:0]  lo_mask;
        logic [`FPN_MANT_W-1:0] mant;
        logic [`FPN_MANT_W:0]   bumped;
        logic                   rnd;
        logic                   stk;
        logic                   inc;
        int                     p;
        int                     d;
        r      = '0;
        rnd    = 1'b0;
        stk    = 1'b0;
        r.sign = sum[`FPN_SUM_W-1];
        mag    = r.sign ? (~sum + 1'b1) : sum;
        // highest set bit between 3 and 17, stays at -1 when there is none
        p = -1;
        for (int i = `FPN_LEAD_LSB; i < `FPN_LEAD_LSB + `FPN_LEAD_W; i++) begin
            tmp = mag >> i;
            if (tmp[0]) begin
                p = i;
            end
        end
        if (p >= 0) begin
            // line bit p-10 up with bit 0, or pad with zeros when p is below 10
            if (p >= `FPN_MANT_W - 1) begin
                tmp = mag >> (p - (`FPN_MANT_W - 1));
            end else begin
                tmp = mag << ((`FPN_MANT_W - 1) - p);
            end
            mant = tmp[`FPN_MANT_W-1:0];
            // round bit is p-11
            if (p >= `FPN_MANT_W) begin
                tmp = mag >> (p - `FPN_MANT_W);
                rnd = tmp[0];
            end
            // sticky covers bits p-12 down to 0
            if (p > `FPN_MANT_W) begin
                lo_mask = ({{(`FPN_SUM_W-1){1'b0}}, 1'b1} << (p - `FPN_MANT_W)) - 1'b1;
                stk     = |(mag & lo_mask);
            end
            inc         = rnd & (mant[0] | stk);
            bumped      = {1'b0, mant} + {{`FPN_MANT_W{1'b0}}, inc};
            r.exp_carry = bumped[`FPN_MANT_W];
            r.mant      = r.exp_carry ? bumped[`FPN_MANT_W:1] : bumped[`FPN_MANT_W-1:0];
            d           = p - `FPN_POINT_POS;
            r.exp_diff  = d[`FPN_EXP_DIFF_W-1:0];
        end
        return r;
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_hist    <= '0;
            sum_d1      <= '0;
            sum_d2      <= '0;
            prev_result <= '0;
        end else begin
            vld_hist    <= {vld_hist[0], i_valid};
            sum_d1      <= i_sum;
            sum_d2      <= sum_d1;
            prev_result <= o_result;
        end
    end

    always_comb begin
        exp_result = model_result(sum_d2);
    end

    // the output strobe is the input strobe two edges later
    a_valid_delay: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid == vld_hist[1])
    else begin
        $error("[FAIL] %0t o_valid expected %0b got %0b",
               $time, $sampled(vld_hist[1]), $sampled(o_valid));
        fail_cnt = fail_cnt + 1;
    end

    // sign, carry, exponent difference and mantissa all come from the model
    a_result: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid |-> (o_result == exp_result))
    else begin
        $error("[FAIL] %0t o_result expected %h got %h",
               $time, $sampled(exp_result), $sampled(o_result));
        fail_cnt = fail_cnt + 1;
    end

    // without a valid strobe the result register keeps its value
    a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !o_valid |-> (o_result == prev_result))
    else begin
        $error("[FAIL] %0t o_result expected %h got %h",
               $time, $sampled(prev_result), $sampled(o_result));
        fail_cnt = fail_cnt + 1;
    end

    // a rounding carry always leaves 10000000000 behind
    a_carry_mant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_valid && o_result.exp_carry) |->
            (o_result.mant == {1'b1, {(`FPN_MANT_W-1){1'b0}}}))
    else begin
        $error("[FAIL] %0t o_result.mant expected %b got %b",
               $time, {1'b1, {(`FPN_MANT_W-1){1'b0}}}, $sampled(o_result.mant));
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind fpn_norm_round_top fpn_norm_round_sva u_sva (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_sum    (i_sum),
    .o_valid  (o_valid),
    .o_result (o_result)
);

/* test/fpn_norm_round_tb.sv */
`timescale 1ns/1ps
`include "fpn_defines.svh"

module fpn_norm_round_tb;

    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 300;
    // reset, about 40 directed samples, the random part and the drain fit well below this
    localparam int MAX_CYCLES    = 400;

    logic                         i_clk;
    logic                         i_arst_n;
    logic                         i_valid;
    logic signed [`FPN_SUM_W-1:0] i_sum;
    logic                         o_valid;
    fpn_pkg::norm_result_t        o_result;

    logic [15:0]                  lfsr;
    logic [`FPN_SUM_W-1:0]        rnd_sum;
    logic [`FPN_SUM_W-1:0]        rnd_vld;
    int                           cycle_cnt;
    int                           tb_errors;
    int                           in_count;
    int                           out_count;
    int                           total_errors;

    fpn_norm_round_top i_dut (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_sum    (i_sum),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #5 i_clk = ~i_clk;
        end
    end

    // 16-bit Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // one LFSR step per bit, bits shift in from the bottom
    task automatic take_bits(input int n, output logic [`FPN_SUM_W-1:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[`FPN_SUM_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [`FPN_SUM_W-1:0] negate_sum(input logic [`FPN_SUM_W-1:0] v);
        return ~v + 1'b1;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic drive_sample(input logic valid, input logic [`FPN_SUM_W-1:0] sum);
        @(posedge i_clk);
        #1;
        i_valid = valid;
        i_sum   = sum;
        if (valid) begin
            in_count++;
        end
    endtask

    // reset state checks and output counting on the falling edge
    always @(negedge i_clk) begin
        if (!i_arst_n) begin
            assert (o_valid == 1'b0) else begin
                $display("[FAIL] %0t o_valid expected 0 got %0b", $time, o_valid);
                tb_errors++;
            end
            assert (o_result == '0) else begin
                $display("[FAIL] %0t o_result expected 0 got %h", $time, o_result);
                tb_errors++;
            end
        end else if (o_valid) begin
            out_count++;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        i_arst_n  = 1'b0;
        i_valid   = 1'b0;
        i_sum     = '0;
        lfsr      = 16'd78;
        cycle_cnt = 0;
        tb_errors = 0;
        in_count  = 0;
        out_count = 0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;

        // +1, -1 and the most negative sum all give zero fields
        drive_sample(1'b1, 19'h00001);
        drive_sample(1'b1, 19'h7FFFF);
        drive_sample(1'b1, 19'h40000);
        drive_sample(1'b0, 19'h00000);

        // single one walked through every searched position, both signs, back to back
        for (int p = 17; p >= 3; p--) begin
            drive_sample(1'b1, 19'h00001 << p);
        end
        for (int p = 17; p >= 3; p--) begin
            drive_sample(1'b1, negate_sum(19'h00001 << p));
        end
        drive_sample(1'b0, 19'h15555);

        // tie with even guard, tie with odd guard, round with sticky
        drive_sample(1'b1, 19'h20040);
        drive_sample(1'b1, 19'h200C0);
        drive_sample(1'b1, 19'h20041);

        // all-ones mantissa with round and sticky carries into the exponent
        drive_sample(1'b1, 19'h3FFC1);
        drive_sample(1'b1, negate_sum(19'h3FFC1));

        // input moves while valid is low so the held result is exercised
        drive_sample(1'b0, 19'h12345);
        drive_sample(1'b0, 19'h6789A);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            take_bits(1, rnd_vld);
            take_bits(`FPN_SUM_W, rnd_sum);
            drive_sample(rnd_vld[0], rnd_sum);
        end
        drive_sample(1'b0, '0);

        // wait for the last item to come out, then make sure nothing extra follows
        while (out_count != in_count) begin
            @(negedge i_clk);
        end
        repeat (3) @(negedge i_clk);
        #1;
        assert (out_count == in_count) else begin
            $display("[FAIL] %0t out_count expected %0d got %0d", $time, in_count, out_count);
            tb_errors++;
        end

        total_errors = i_dut.u_sva.fail_cnt + tb_errors;
        $display("error counts: assertions %0d, testbench %0d",
                 i_dut.u_sva.fail_cnt, tb_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/fpn_pkg.sv
hw/fpn_magnitude_lod.sv
hw/fpn_normalizer.sv
hw/fpn_rne_rounder.sv
hw/fpn_norm_round_top.sv
test/fpn_norm_round_sva.sv
test/fpn_norm_round_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the normalize-and-round testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

TOP=fpn_norm_round_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi
